// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - cpu_isa_pkg.sv
  - cpu_pipe_pkg.sv
  - cpu_regfile.sv
  - cpu_decode.sv
  - cpu_exec.sv
  - cpu_mem_wb.sv
  - cpu_core.sv
  - target: test
    files:
      - tb_cpu_core.sv

// ==== cpu_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_core (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_valid,
	input  logic [31:0]        i_instr,
	input  logic [31:0]        i_pc_plus_4,
	output logic               o_branch_taken,
	output logic [31:0]        o_branch_target,
	output cpu_pipe_pkg::wb_t  o_wb
);

	import cpu_pipe_pkg::*;

	logic [3:0]   ra_sel;
	logic [3:0]   rb_sel;
	logic [31:0]  ra_val;
	logic [31:0]  rb_val;
	dec_to_exec_t dec;
	exec_to_mem_t mem;

	cpu_regfile cpu_regfile_inst (
		.clk      (clk),
		.rst      (rst),
		.i_ra_sel (ra_sel),
		.i_rb_sel (rb_sel),
		.o_ra_val (ra_val),
		.o_rb_val (rb_val),
		.i_wb     (o_wb)
	);

	cpu_decode cpu_decode_inst (
		.clk         (clk),
		.rst         (rst),
		.i_valid     (i_valid),
		.i_instr     (i_instr),
		.i_pc_plus_4 (i_pc_plus_4),
		.o_ra_sel    (ra_sel),
		.o_rb_sel    (rb_sel),
		.i_ra_val    (ra_val),
		.i_rb_val    (rb_val),
		.o_dec       (dec)
	);

	cpu_exec cpu_exec_inst (
		.clk             (clk),
		.rst             (rst),
		.i_dec           (dec),
		.o_mem           (mem),
		.o_branch_taken  (o_branch_taken),
		.o_branch_target (o_branch_target)
	);

	// Writeback also feeds the register file write port.
	cpu_mem_wb cpu_mem_wb_inst (
		.clk   (clk),
		.rst   (rst),
		.i_mem (mem),
		.o_wb  (o_wb)
	);

endmodule

`default_nettype wire

// ==== cpu_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_decode (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        i_valid,
	input  logic [31:0]                 i_instr,
	input  logic [31:0]                 i_pc_plus_4,
	output logic [3:0]                  o_ra_sel,
	output logic [3:0]                  o_rb_sel,
	input  logic [31:0]                 i_ra_val,
	input  logic [31:0]                 i_rb_val,
	output cpu_pipe_pkg::dec_to_exec_t  o_dec
);

	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	dec_to_exec_t dec_next;
	class_e       iclass;
	alu_opc_e     alu_opc;
	logic [3:0]   rd;
	logic         is_call;

	assign iclass   = class_e'(i_instr[F_CLASS_HI:F_CLASS_LO]);
	assign alu_opc  = alu_opc_e'(i_instr[F_OPC_HI:F_OPC_LO]);
	assign rd       = i_instr[F_RD_HI:F_RD_LO];
	assign is_call  = iclass == CLASS_BRANCH && rd != 4'd0;
	assign o_ra_sel = i_instr[F_RA_HI:F_RA_LO];
	assign o_rb_sel = i_instr[F_RB_HI:F_RB_LO];

	always_comb begin
		dec_next.valid        = i_valid;
		dec_next.ra_val       = i_ra_val;
		dec_next.rb_val       = i_rb_val;
		dec_next.imm32        = {{16{i_instr[F_IMM_HI]}}, i_instr[F_IMM_HI:F_IMM_LO]};
		dec_next.pc_plus_4    = i_pc_plus_4;
		dec_next.rd           = rd;
		dec_next.update_rd    = (iclass == CLASS_ARITH && alu_opc != ALU_CMP) ||
			iclass == CLASS_LOAD || is_call;
		dec_next.alu_opc      = alu_opc;
		dec_next.op1_is_pc    = iclass == CLASS_BRANCH; // Branch targets are pc relative.
		dec_next.op2_is_rb    = i_instr[F_OP2_RB];
		dec_next.iclass       = iclass;
		dec_next.cond         = branch_cond_e'(i_instr[F_COND_HI:F_COND_LO]);
		dec_next.mem_width    = mem_width_e'(i_instr[F_MW_HI:F_MW_LO]);
		dec_next.is_call      = is_call;
		dec_next.update_flags = i_instr[F_UPD_FLAGS];
		dec_next.update_carry = i_instr[F_UPD_CARRY];
	end

	always_ff @(posedge clk) begin
		o_dec <= dec_next;
		if (rst)
			o_dec.valid <= 1'b0;
	end

	a_class_known: assert property (@(posedge clk) disable iff (rst)
		i_valid |-> !$isunknown(i_instr[F_CLASS_HI:F_CLASS_LO]));

endmodule

`default_nettype wire

// ==== cpu_exec.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_exec (
	input  logic                        clk,
	input  logic                        rst,
	input  cpu_pipe_pkg::dec_to_exec_t  i_dec,
	output cpu_pipe_pkg::exec_to_mem_t  o_mem,
	output logic                        o_branch_taken,
	output logic [31:0]                 o_branch_target
);

	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	logic [31:0]  op1;
	logic [31:0]  op2;
	logic [31:0]  alu_q;
	logic         alu_c;
	logic         alu_n;
	logic         alu_o;
	logic         alu_z;
	logic         z_flag;
	logic         c_flag;
	logic         n_flag;
	logic         o_flag;
	logic         cond_met;
	logic         is_load;
	logic         is_store;
	exec_to_mem_t mem_next;

	assign op1   = i_dec.op1_is_pc ? i_dec.pc_plus_4 : i_dec.ra_val;
	assign op2   = i_dec.op2_is_rb ? i_dec.rb_val : i_dec.imm32;
	assign alu_z = op1 == op2;

	assign is_load  = i_dec.iclass == CLASS_LOAD;
	assign is_store = i_dec.iclass == CLASS_STORE;

	always_comb begin
		alu_q = '0;
		alu_c = 1'b0;
		alu_n = 1'b0;
		alu_o = 1'b0;

		case (i_dec.alu_opc)
		ALU_ADD:   {alu_c, alu_q} = {1'b0, op1} + {1'b0, op2};
		ALU_ADDC:  {alu_c, alu_q} = {1'b0, op1} + {1'b0, op2} + {32'b0, c_flag};
		ALU_SUB:   {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2};
		ALU_SUBC:  {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2} - {32'b0, c_flag};
		ALU_LSL:   {alu_c, alu_q} = {1'b0, op1} << op2[4:0]; // Carry gets the last bit out.
		ALU_LSR:   alu_q = op1 >> op2[4:0];
		ALU_AND:   alu_q = op1 & op2;
		ALU_XOR:   alu_q = op1 ^ op2;
		ALU_BIC:   alu_q = op1 & ~(32'd1 << op2[4:0]);
		ALU_BST:   alu_q = op1 | (32'd1 << op2[4:0]);
		ALU_OR:    alu_q = op1 | op2;
		ALU_COPYB: alu_q = op2;
		ALU_CMP: begin
			{alu_c, alu_q} = {1'b0, op1} - {1'b0, op2};
			// Signed overflow of op1 - op2.
			alu_o = (op1[31] ^ op2[31]) && (alu_q[31] == op2[31]);
			alu_n = alu_q[31];
		end
		ALU_MOVHI: alu_q = op1 | {16'b0, op2[15:0]};
		ALU_ASR:   alu_q = $signed(op1) >>> op2[4:0];
		ALU_COPYA: alu_q = op1;
		default:   alu_q = '0;
		endcase
	end

	always_comb begin
		case (i_dec.cond)
		COND_NEVER:  cond_met = 1'b0;
		COND_NE:     cond_met = !z_flag;
		COND_EQ:     cond_met = z_flag;
		COND_CC:     cond_met = !c_flag;
		COND_CS:     cond_met = c_flag;
		COND_GT:     cond_met = !z_flag && (n_flag == o_flag);
		COND_LT:     cond_met = n_flag != o_flag;
		COND_ALWAYS: cond_met = 1'b1;
		default:     cond_met = 1'b0;
		endcase
	end

	// Flags only move for valid instructions that ask for it.
	always_ff @(posedge clk) begin
		if (rst) begin
			z_flag <= 1'b0;
			c_flag <= 1'b0;
			n_flag <= 1'b0;
			o_flag <= 1'b0;
		end else if (i_dec.valid) begin
			if (i_dec.update_flags) begin
				z_flag <= alu_z;
				n_flag <= alu_n;
				o_flag <= alu_o;
			end
			if (i_dec.update_carry)
				c_flag <= alu_c;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			o_branch_taken <= 1'b0;
		else
			o_branch_taken <= i_dec.valid && i_dec.iclass == CLASS_BRANCH && cond_met;
		o_branch_target <= alu_q; // pc_plus_4 + imm32.
	end

	always_comb begin
		mem_next.valid     = i_dec.valid;
		mem_next.rd        = i_dec.rd;
		mem_next.update_rd = i_dec.update_rd;
		mem_next.is_load   = is_load;
		mem_next.is_store  = is_store;
		mem_next.mem_width = (is_load || is_store) ? i_dec.mem_width : o_mem.mem_width;
		mem_next.mar       = (is_load || is_store) ? alu_q : o_mem.mar;
		mem_next.mdr       = is_store ? i_dec.rb_val : o_mem.mdr;
		mem_next.wr_val    = i_dec.is_call ? i_dec.pc_plus_4 : is_store ? op2 : alu_q;
	end

	always_ff @(posedge clk) begin
		o_mem <= mem_next;
		if (rst)
			o_mem.valid <= 1'b0;
	end

	a_mem_width_legal: assert property (@(posedge clk) disable iff (rst)
		o_mem.valid && (o_mem.is_load || o_mem.is_store) |-> o_mem.mem_width != 2'b11);

endmodule

`default_nettype wire

// ==== cpu_isa_pkg.sv ====
`default_nettype none

package cpu_isa_pkg;

	// Instruction word field positions.
	localparam int F_CLASS_HI  = 31;
	localparam int F_CLASS_LO  = 30;
	localparam int F_OPC_HI    = 29;
	localparam int F_OPC_LO    = 25;
	localparam int F_RD_HI     = 24;
	localparam int F_RD_LO     = 21;
	localparam int F_RA_HI     = 20;
	localparam int F_RA_LO     = 17;
	localparam int F_RB_HI     = 16;
	localparam int F_RB_LO     = 13;
	localparam int F_OP2_RB    = 12;
	localparam int F_UPD_FLAGS = 11;
	localparam int F_UPD_CARRY = 10;
	localparam int F_COND_HI   = 9;
	localparam int F_COND_LO   = 7;
	localparam int F_MW_HI     = 8; // Memory width shares the condition field.
	localparam int F_MW_LO     = 7;
	localparam int F_IMM_HI    = 15;
	localparam int F_IMM_LO    = 0;

	typedef enum logic [4:0] {
		ALU_ADD   = 5'h00,
		ALU_ADDC  = 5'h01,
		ALU_SUB   = 5'h02,
		ALU_SUBC  = 5'h03,
		ALU_LSL   = 5'h04,
		ALU_LSR   = 5'h05,
		ALU_AND   = 5'h06,
		ALU_XOR   = 5'h07,
		ALU_BIC   = 5'h08,
		ALU_BST   = 5'h09,
		ALU_OR    = 5'h0a,
		ALU_COPYB = 5'h0b,
		ALU_CMP   = 5'h0c,
		ALU_MOVHI = 5'h0d,
		ALU_ASR   = 5'h0e,
		ALU_COPYA = 5'h0f
	} alu_opc_e;

	typedef enum logic [1:0] {
		CLASS_ARITH  = 2'b00,
		CLASS_BRANCH = 2'b01,
		CLASS_LOAD   = 2'b10,
		CLASS_STORE  = 2'b11
	} class_e;

	typedef enum logic [2:0] {
		COND_NEVER  = 3'b000,
		COND_NE     = 3'b001,
		COND_EQ     = 3'b010,
		COND_CC     = 3'b011,
		COND_CS     = 3'b100,
		COND_GT     = 3'b101,
		COND_LT     = 3'b110,
		COND_ALWAYS = 3'b111
	} branch_cond_e;

	typedef enum logic [1:0] {
		MEM_BYTE = 2'b00,
		MEM_HALF = 2'b01,
		MEM_WORD = 2'b10
	} mem_width_e;

endpackage

`default_nettype wire

// ==== cpu_mem_wb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_mem_wb (
	input  logic                        clk,
	input  logic                        rst,
	input  cpu_pipe_pkg::exec_to_mem_t  i_mem,
	output cpu_pipe_pkg::wb_t           o_wb
);

	import cpu_isa_pkg::*;
	import cpu_pipe_pkg::*;

	logic [31:0]                     dmem [DMEM_WORDS];
	logic [$clog2(DMEM_WORDS)-1:0]   word_addr;
	logic [31:0]                     rd_word;
	logic [31:0]                     load_val;
	wb_t                             wb_next;

	assign word_addr = i_mem.mar[$clog2(DMEM_WORDS)+1:2];
	assign rd_word   = dmem[word_addr];

	always_ff @(posedge clk) begin
		if (i_mem.valid && i_mem.is_store) begin
			case (i_mem.mem_width)
			MEM_BYTE: dmem[word_addr][{i_mem.mar[1:0], 3'b000} +: 8] <= i_mem.mdr[7:0];
			MEM_HALF: dmem[word_addr][{i_mem.mar[1], 4'b0000} +: 16] <= i_mem.mdr[15:0];
			MEM_WORD: dmem[word_addr] <= i_mem.mdr;
			default:  ;
			endcase
		end
	end

	// Loads return the addressed lane, zero extended.
	always_comb begin
		case (i_mem.mem_width)
		MEM_BYTE: load_val = {24'b0, rd_word[{i_mem.mar[1:0], 3'b000} +: 8]};
		MEM_HALF: load_val = {16'b0, rd_word[{i_mem.mar[1], 4'b0000} +: 16]};
		default:  load_val = rd_word;
		endcase
	end

	always_comb begin
		wb_next.valid = i_mem.valid && i_mem.update_rd;
		wb_next.rd    = i_mem.rd;
		wb_next.value = i_mem.is_load ? load_val : i_mem.wr_val;
	end

	always_ff @(posedge clk) begin
		o_wb <= wb_next;
		if (rst)
			o_wb.valid <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== cpu_pipe_pkg.sv ====
`default_nettype none

package cpu_pipe_pkg;

	localparam int DMEM_WORDS = 64;

	// Decode to execute.
	typedef struct packed {
		logic                       valid;
		logic [31:0]                ra_val;
		logic [31:0]                rb_val;
		logic [31:0]                imm32;
		logic [31:0]                pc_plus_4;
		logic [3:0]                 rd;
		logic                       update_rd;
		cpu_isa_pkg::alu_opc_e      alu_opc;
		logic                       op1_is_pc;
		logic                       op2_is_rb;
		cpu_isa_pkg::class_e        iclass;
		cpu_isa_pkg::branch_cond_e  cond;
		cpu_isa_pkg::mem_width_e    mem_width;
		logic                       is_call;
		logic                       update_flags;
		logic                       update_carry;
	} dec_to_exec_t;

	// Execute to memory/writeback.
	typedef struct packed {
		logic                       valid;
		logic [3:0]                 rd;
		logic                       update_rd;
		logic                       is_load;
		logic                       is_store;
		cpu_isa_pkg::mem_width_e    mem_width;
		logic [31:0]                mar;
		logic [31:0]                mdr;
		logic [31:0]                wr_val;
	} exec_to_mem_t;

	typedef struct packed {
		logic                       valid;
		logic [3:0]                 rd;
		logic [31:0]                value;
	} wb_t;

endpackage

`default_nettype wire

// ==== cpu_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_regfile (
	input  logic               clk,
	input  logic               rst,
	input  logic [3:0]         i_ra_sel,
	input  logic [3:0]         i_rb_sel,
	output logic [31:0]        o_ra_val,
	output logic [31:0]        o_rb_val,
	input  cpu_pipe_pkg::wb_t  i_wb
);

	logic [31:0] regs [16];

	// A read in the writeback cycle sees the value being written.
	always_comb begin
		if (i_ra_sel == 4'd0)
			o_ra_val = '0;
		else if (i_wb.valid && i_wb.rd == i_ra_sel)
			o_ra_val = i_wb.value;
		else
			o_ra_val = regs[i_ra_sel];

		if (i_rb_sel == 4'd0)
			o_rb_val = '0;
		else if (i_wb.valid && i_wb.rd == i_rb_sel)
			o_rb_val = i_wb.value;
		else
			o_rb_val = regs[i_rb_sel];
	end

	always_ff @(posedge clk) begin
		if (i_wb.valid && i_wb.rd != 4'd0)
			regs[i_wb.rd] <= i_wb.value;
	end

	a_wb_rd_known: assert property (@(posedge clk) disable iff (rst)
		i_wb.valid |-> !$isunknown(i_wb.rd));

endmodule

`default_nettype wire

// ==== cpu_stimulus.hex ====
// valid instr pc_plus_4 wb_valid wb_rd wb_value br_valid br_target
// Dependent instructions sit at least three records after their producer.
1 00200123 00000000 1 1 00000123 0 00000000 // add r1, r0, 0x123
1 0040e300 00000000 1 2 ffffe300 0 00000000 // add r2, r0, 0xe300
1 00600005 00000000 1 3 00000005 0 00000000 // add r3, r0, 5
1 008000f0 00000000 1 4 000000f0 0 00000000 // add r4, r0, 0xf0
1 1aa20340 00000000 1 5 00000363 0 00000000 // movhi r5, r1, 0x340
1 04c47000 00000000 1 6 ffffe2fb 0 00000000 // sub r6, r2, r3
1 0ce403f8 00000000 1 7 00000300 0 00000000 // and r7, r2, 0x3f8
1 15029000 00000000 1 8 000001f3 0 00000000 // or r8, r1, r4
1 0f243000 00000000 1 9 ffffe223 0 00000000 // xor r9, r2, r1
1 09420004 00000000 1 a 00001230 0 00000000 // lsl r10, r1, 4
1 0b647000 00000000 1 b 07ffff18 0 00000000 // lsr r11, r2, r3
1 1d840008 00000000 1 c ffffffe3 0 00000000 // asr r12, r2, 8
1 11a80004 00000000 1 d 000000e0 0 00000000 // bic r13, r4, 4
1 13c6001f 00000000 1 e 80000005 0 00000000 // bst r14, r3, 31
1 17e00077 00000000 1 f 00000077 0 00000000 // copyb r15, 0x77
1 00020001 00000000 1 0 00000124 0 00000000 // add r0, r1, 1
1 1ebc0000 00000000 1 5 80000005 0 00000000 // copya r5, r14
1 00c59400 00000000 1 6 ffffe2e3 0 00000000 // add r6, r2, r12 with carry out
1 02e27000 00000000 1 7 00000129 0 00000000 // addc r7, r1, r3
1 07087000 00000000 1 8 000000ea 0 00000000 // subc r8, r4, r3
1 1f200000 00000000 1 9 00000000 0 00000000 // copya r9, r0
1 18063c00 00000000 0 0 00000000 0 00000000 // cmp r3, r1
1 40000110 00001000 0 0 00000000 0 00000000 // beq
1 40000090 00001004 0 0 00000000 1 00001094 // bne
1 40000310 00001008 0 0 00000000 1 00001318 // blt
1 40000290 0000100c 0 0 00000000 0 00000000 // bgt
1 40000210 00001010 0 0 00000000 1 00001220 // bcs
1 40000190 00001014 0 0 00000000 0 00000000 // bcc
1 18027c00 00000000 0 0 00000000 0 00000000 // cmp r1, r3
1 40000290 00002000 0 0 00000000 1 00002290 // bgt
1 40000190 00002004 0 0 00000000 1 00002194 // bcc
1 40000310 00002008 0 0 00000000 0 00000000 // blt
1 18067c00 00000000 0 0 00000000 0 00000000 // cmp r3, r3
1 40000110 00003000 0 0 00000000 1 00003110 // beq
1 40000090 00003004 0 0 00000000 0 00000000 // bne
1 41400390 00004000 1 a 00004000 1 00004390 // call r10
1 c000c110 00000000 0 0 00000000 0 00000000 // sw r6 to word 4
1 c0004096 00000000 0 0 00000000 0 00000000 // sh r2 to word 37 upper half
1 c000c023 00000000 0 0 00000000 0 00000000 // sb r6 to word 8 byte 3
1 81600110 00000000 1 b ffffe2e3 0 00000000 // lw r11
1 81800096 00000000 1 c 0000e300 0 00000000 // lh r12
1 81a00023 00000000 1 d 000000e3 0 00000000 // lb r13

// ==== tb.f ====
cpu_isa_pkg.sv
cpu_pipe_pkg.sv
cpu_regfile.sv
cpu_decode.sv
cpu_exec.sv
cpu_mem_wb.sv
cpu_core.sv
tb_cpu_core.sv

// ==== tb_cpu_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_core;

	import cpu_pipe_pkg::*;

	localparam int REC_WORDS = 8;
	localparam int REC_MAX   = 64;
	localparam int WB_LAT    = 3;
	localparam int BR_LAT    = 2;
	localparam int DRAIN_MAX = 50;

	// Word offsets inside one stimulus record.
	localparam int R_VALID = 0;
	localparam int R_INSTR = 1;
	localparam int R_PC    = 2;
	localparam int R_WBV   = 3;
	localparam int R_WBRD  = 4;
	localparam int R_WBVAL = 5;
	localparam int R_BRV   = 6;
	localparam int R_BRTGT = 7;

	logic        clk;
	logic        rst;
	logic        i_valid;
	logic [31:0] i_instr;
	logic [31:0] i_pc_plus_4;
	logic        o_branch_taken;
	logic [31:0] o_branch_target;
	wb_t         o_wb;

	logic [31:0] stim [REC_MAX*REC_WORDS];

	// Expected events, stamped with the cycle they must show up in.
	int          wb_when [$];
	logic [3:0]  wb_rd [$];
	logic [31:0] wb_value [$];
	int          br_when [$];
	logic [31:0] br_target [$];
	int          cyc;

	cpu_core cpu_core_inst (
		.clk             (clk),
		.rst             (rst),
		.i_valid         (i_valid),
		.i_instr         (i_instr),
		.i_pc_plus_4     (i_pc_plus_4),
		.o_branch_taken  (o_branch_taken),
		.o_branch_target (o_branch_target),
		.o_wb            (o_wb)
	);

	always #2 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			$display("TEST FAIL");
			$fatal(1, "Mismatch on %s.", name);
		end
	endtask

	task automatic drive_record(input int idx);
		int base;
		base = idx * REC_WORDS;
		i_valid     <= stim[base + R_VALID][0];
		i_instr     <= stim[base + R_INSTR];
		i_pc_plus_4 <= stim[base + R_PC];
		if (stim[base + R_WBV][0]) begin
			wb_when.push_back(cyc + WB_LAT);
			wb_rd.push_back(stim[base + R_WBRD][3:0]);
			wb_value.push_back(stim[base + R_WBVAL]);
		end
		if (stim[base + R_BRV][0]) begin
			br_when.push_back(cyc + BR_LAT);
			br_target.push_back(stim[base + R_BRTGT]);
		end
	endtask

	// Sampled mid-cycle, half a period away from the driving edge.
	always @(negedge clk) begin
		if (!rst) begin
			if (wb_when.size() > 0 && wb_when[0] == cyc) begin
				check_value("o_wb.valid", o_wb.valid, 1'b1);
				check_value("o_wb.rd", o_wb.rd, wb_rd[0]);
				check_value("o_wb.value", o_wb.value, wb_value[0]);
				wb_when.delete(0);
				wb_rd.delete(0);
				wb_value.delete(0);
			end else begin
				check_value("o_wb.valid", o_wb.valid, 1'b0);
			end
			if (br_when.size() > 0 && br_when[0] == cyc) begin
				check_value("o_branch_taken", o_branch_taken, 1'b1);
				check_value("o_branch_target", o_branch_target, br_target[0]);
				br_when.delete(0);
				br_target.delete(0);
			end else begin
				check_value("o_branch_taken", o_branch_taken, 1'b0); // No stray pulses.
			end
		end
		cyc = cyc + 1;
	end

	initial begin
		int n_rec;
		int drain;
		clk         = 1'b0;
		rst         = 1'b1;
		i_valid     = 1'b0;
		i_instr     = '0;
		i_pc_plus_4 = '0;
		cyc         = 0;
		$readmemh("cpu_stimulus.hex", stim);
		n_rec = 0;
		while (n_rec < REC_MAX && !$isunknown(stim[n_rec * REC_WORDS]))
			n_rec++;

		repeat (4) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < n_rec; i++) begin
			@(posedge clk);
			drive_record(i);
		end
		@(posedge clk);
		i_valid <= 1'b0;

		drain = 0;
		while ((wb_when.size() != 0 || br_when.size() != 0) && drain < DRAIN_MAX) begin
			@(posedge clk);
			drain++;
		end

		if (wb_when.size() != 0 || br_when.size() != 0) begin
			$display("Timed out waiting for the expected writebacks and branches.");
			$display("TEST FAIL");
			$fatal(1, "Drain timeout.");
		end else if (n_rec == 0) begin
			$display("No stimulus records were read from cpu_stimulus.hex.");
			$display("TEST FAIL");
			$fatal(1, "Empty stimulus.");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire
